// File: eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // 24C16 family device type, upper nibble of the control byte
    localparam logic [3:0] eeprom_dev_code = 4'b1010;

    // r/w bit at the bottom of the control byte
    localparam logic rw_write = 1'b0;
    localparam logic rw_read  = 1'b1;

    // field view of the control byte, msb first on the wire
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;    // addr[10:8], selects the 256 byte block
        logic       rw;
    } ctrl_byte_fields_t;

    // the shifters see the raw byte
    // the controller builds it and the slave decodes it field by field
    typedef union packed {
        logic [7:0]        raw;
        ctrl_byte_fields_t fields;
    } ctrl_byte_u;

endpackage

// File: eeprom_ctrl_pkg.sv
package eeprom_ctrl_pkg;

    typedef logic [10:0] eeprom_addr_t;   // 2 Kbyte array

    // host request as captured on the wr/rd strobe
    typedef struct packed {
        eeprom_addr_t addr;
        logic [7:0]   wdata;
        logic         is_read;
    } eeprom_req_t;

    // bit engine operations
    // op_byte_in is reserved, the read path uses op_nomack
    typedef enum logic [2:0] {
        op_start,
        op_stop,
        op_byte_out,
        op_byte_in,
        op_mack,
        op_nomack
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] tx_byte;  // only used by op_byte_out
    } bit_cmd_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr,
        st_data_wr,
        st_restart,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_done
    } xfer_state_e;

endpackage

// File: i2c_scl_gen.sv
`timescale 1ns/100ps

module i2c_scl_gen #(
    parameter int scl_half_div = 4   // needs 3 or more for back to back ops
) (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic scl_low_mid,
    output logic scl_rise,
    output logic scl_high_mid
);

    localparam int period      = 2 * scl_half_div;
    localparam int cnt_w       = $clog2(period);
    // scl is low for cnt 1..half, high for the rest of the period
    localparam int low_mid_pt  = scl_half_div / 2 + 1;
    localparam int rise_pt     = scl_half_div + 1;
    localparam int high_mid_pt = scl_half_div + 1 + scl_half_div / 2;

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            cnt <= '0;
            scl <= 1'b1;   // bus idles with scl high
        end else begin
            cnt <= (cnt == cnt_w'(period - 1)) ? '0 : cnt + 1'b1;
            scl <= (cnt >= cnt_w'(scl_half_div));
        end
    end

    assign scl_low_mid  = run && (cnt == cnt_w'(low_mid_pt));
    assign scl_rise     = run && (cnt == cnt_w'(rise_pt));
    assign scl_high_mid = run && (cnt == cnt_w'(high_mid_pt));

    // phase points must be distinct for every divider setting in use
    a_strobes_apart: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0({scl_low_mid, scl_rise, scl_high_mid}));

endmodule

// File: i2c_bit_tx.sv
`timescale 1ns/100ps

module i2c_bit_tx (
    input  logic                      CLK,
    input  logic                      RESET,
    input  eeprom_ctrl_pkg::bit_cmd_t cmd,
    input  logic                      cmd_go,
    input  logic                      scl_low_mid,
    input  logic                      scl_high_mid,
    input  logic                      scl_rise,
    output logic                      bit_done,
    output logic                      sda_drive_low
);

    import eeprom_ctrl_pkg::*;

    // one scl period is walked low_mid -> rise -> high_mid
    typedef enum logic [1:0] {
        ph_idle,
        ph_low,
        ph_rise,
        ph_high
    } phase_e;

    phase_e     phase;
    bit_op_e    op;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       last_bit;
    logic       ack_low;

    // start and stop are a single period, byte ops run 9
    assign last_bit = (op == op_start) || (op == op_stop) || (bit_cnt == 4'd8);
    assign ack_low  = (op == op_byte_in) || (op == op_mack);   // we acknowledge

    always_ff @(posedge CLK) begin
        if (RESET) begin
            phase         <= ph_idle;
            bit_cnt       <= '0;
            bit_done      <= 1'b0;
            sda_drive_low <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (cmd_go) begin
                        bit_cnt <= '0;
                        phase   <= ph_low;
                    end
                end
                ph_low: begin
                    if (scl_low_mid) begin
                        phase <= ph_rise;
                        case (op)
                            op_start: sda_drive_low <= 1'b0;
                            op_stop:  sda_drive_low <= 1'b1;
                            default: begin
                                if (bit_cnt == 4'd8) begin
                                    sda_drive_low <= ack_low;
                                end else begin
                                    sda_drive_low <= (op == op_byte_out) && !shreg[7];
                                end
                            end
                        endcase
                    end
                end
                ph_rise: begin
                    if (scl_rise) begin
                        phase <= ph_high;
                    end
                end
                ph_high: begin
                    if (scl_high_mid) begin
                        if (op == op_start) begin
                            sda_drive_low <= 1'b1;   // sda falls with scl high
                        end else if (op == op_stop) begin
                            sda_drive_low <= 1'b0;   // sda rises with scl high
                        end
                        if (last_bit) begin
                            phase    <= ph_idle;
                            bit_done <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            phase   <= ph_low;
                        end
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    // command and shift data
    always_ff @(posedge CLK) begin
        if (phase == ph_idle && cmd_go) begin
            op    <= cmd.op;
            shreg <= cmd.tx_byte;
        end else if (phase == ph_low && scl_low_mid && bit_cnt != 4'd8) begin
            shreg <= {shreg[6:0], 1'b0};   // msb first
        end
    end

    // the controller waits for bit_done before the next op
    a_go_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_go |-> phase == ph_idle);

endmodule

// File: i2c_byte_rx.sv
`timescale 1ns/100ps

module i2c_byte_rx (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       sda_in,
    input  logic       scl_high_mid,
    input  logic       sample_clr,
    output logic [7:0] rx_byte,
    output logic       rx_ack_bit
);

    logic [1:0] sda_sync;   // pad is asynchronous to CLK
    logic [8:0] samples;
    logic [3:0] cnt;
    logic       take;

    always_ff @(posedge CLK) begin
        sda_sync <= {sda_sync[0], sda_in};
    end

    // stop after nine samples so later start/stop slots leave the byte alone
    assign take = scl_high_mid && (cnt != 4'd9) && !sample_clr;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cnt <= '0;
        end else if (sample_clr) begin
            cnt <= '0;
        end else if (take) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            samples <= {samples[7:0], sda_sync[1]};
        end
    end

    assign rx_byte    = samples[8:1];   // data, msb first on the wire
    assign rx_ack_bit = samples[0];     // ninth clock, 0 = acked

endmodule

// File: eeprom_rw_ctrl.sv
`timescale 1ns/100ps

module eeprom_rw_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  eeprom_ctrl_pkg::eeprom_addr_t addr,
    input  logic [7:0]                    wdata,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack_err,
    output logic [7:0]                    rdata,
    output logic                          run,
    output eeprom_ctrl_pkg::bit_cmd_t     cmd,
    output logic                          cmd_go,
    output logic                          sample_clr,
    input  logic                          bit_done,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_ack_bit
);

    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;

    xfer_state_e state;
    xfer_state_e nxt;
    eeprom_req_t req;
    eeprom_req_t req_in;
    eeprom_req_t req_src;
    logic        launch;      // start the bit op of nxt
    logic        nack_pend;
    logic        ack_slot;    // byte ops where the device must ack

    function automatic logic [7:0] ctrl_byte(eeprom_addr_t a, logic rw);
        ctrl_byte_u cb;
        cb.fields.dev_code = eeprom_dev_code;
        cb.fields.block    = a[10:8];
        cb.fields.rw       = rw;
        return cb.raw;
    endfunction

    function automatic bit_cmd_t cmd_for(xfer_state_e s, eeprom_req_t r);
        bit_cmd_t c;
        c.op      = op_byte_out;
        c.tx_byte = 8'h00;
        case (s)
            st_start, st_restart: c.op = op_start;
            st_ctrl_wr: c.tx_byte = ctrl_byte(r.addr, rw_write);
            st_addr:    c.tx_byte = r.addr[7:0];
            st_data_wr: c.tx_byte = r.wdata;
            st_ctrl_rd: c.tx_byte = ctrl_byte(r.addr, rw_read);
            st_data_rd: c.op = op_nomack;   // single byte, master does not ack
            default:    c.op = op_stop;
        endcase
        return c;
    endfunction

    assign req_in   = '{addr: addr, wdata: wdata, is_read: rd};
    assign req_src  = (state == st_idle) ? req_in : req;
    assign ack_slot = state inside {st_ctrl_wr, st_addr, st_data_wr, st_ctrl_rd};
    assign busy     = (state != st_idle);
    // drop run right at the stop's bit_done so scl stays high afterwards
    assign run      = busy && (state != st_done) && !(state == st_stop && bit_done);

    always_comb begin
        nxt    = state;
        launch = 1'b0;
        case (state)
            st_idle: begin
                if (wr || rd) begin
                    nxt    = st_start;
                    launch = 1'b1;
                end
            end
            st_done: nxt = st_idle;
            default: begin
                if (bit_done) begin
                    launch = 1'b1;
                    case (state)
                        st_start:   nxt = st_ctrl_wr;
                        st_ctrl_wr: nxt = rx_ack_bit ? st_stop : st_addr;
                        st_addr: begin
                            if (rx_ack_bit) begin
                                nxt = st_stop;
                            end else begin
                                nxt = req.is_read ? st_restart : st_data_wr;
                            end
                        end
                        st_restart: nxt = st_ctrl_rd;
                        st_ctrl_rd: nxt = rx_ack_bit ? st_stop : st_data_rd;
                        st_data_wr, st_data_rd: nxt = st_stop;
                        default: begin   // stop finished
                            nxt    = st_done;
                            launch = 1'b0;
                        end
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state      <= st_idle;
            cmd_go     <= 1'b0;
            sample_clr <= 1'b0;
            ack        <= 1'b0;
            nack_err   <= 1'b0;
            nack_pend  <= 1'b0;
        end else begin
            state      <= nxt;
            cmd_go     <= launch;
            sample_clr <= launch;
            ack        <= (state == st_done);
            nack_err   <= (state == st_done) && nack_pend;
            if (state == st_idle) begin
                nack_pend <= 1'b0;
            end else if (ack_slot && bit_done && rx_ack_bit) begin
                nack_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (launch) begin
            cmd <= cmd_for(nxt, req_src);
        end
        if (state == st_idle && (wr || rd)) begin
            req <= req_in;
        end
        if (state == st_data_rd && bit_done) begin
            rdata <= rx_byte;   // held until the next read
        end
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // no bus activity outside a transaction
    a_go_busy: assert property (@(posedge CLK) disable iff (RESET)
        cmd_go |-> busy);

endmodule

// File: eeprom_i2c_top.sv
`timescale 1ns/100ps

module eeprom_i2c_top #(
    parameter int scl_half_div = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  eeprom_ctrl_pkg::eeprom_addr_t addr,
    input  logic [7:0]                    wdata,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack_err,
    output logic [7:0]                    rdata,
    inout  wire                           sda,
    output logic                          scl
);

    import eeprom_ctrl_pkg::*;

    bit_cmd_t   cmd;
    logic       cmd_go;
    logic       bit_done;
    logic       run;
    logic       sample_clr;
    logic       scl_low_mid;
    logic       scl_rise;
    logic       scl_high_mid;
    logic       sda_drive_low;
    logic [7:0] rx_byte;
    logic       rx_ack_bit;

    eeprom_rw_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .busy       (busy),
        .ack        (ack),
        .nack_err   (nack_err),
        .rdata      (rdata),
        .run        (run),
        .cmd        (cmd),
        .cmd_go     (cmd_go),
        .sample_clr (sample_clr),
        .bit_done   (bit_done),
        .rx_byte    (rx_byte),
        .rx_ack_bit (rx_ack_bit)
    );

    i2c_scl_gen #(
        .scl_half_div (scl_half_div)
    ) u_scl_gen (
        .CLK          (CLK),
        .RESET        (RESET),
        .run          (run),
        .scl          (scl),
        .scl_low_mid  (scl_low_mid),
        .scl_rise     (scl_rise),
        .scl_high_mid (scl_high_mid)
    );

    i2c_bit_tx u_bit_tx (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd),
        .cmd_go        (cmd_go),
        .scl_low_mid   (scl_low_mid),
        .scl_high_mid  (scl_high_mid),
        .scl_rise      (scl_rise),
        .bit_done      (bit_done),
        .sda_drive_low (sda_drive_low)
    );

    i2c_byte_rx u_byte_rx (
        .CLK          (CLK),
        .RESET        (RESET),
        .sda_in       (sda),
        .scl_high_mid (scl_high_mid),
        .sample_clr   (sample_clr),
        .rx_byte      (rx_byte),
        .rx_ack_bit   (rx_ack_bit)
    );

    assign sda = sda_drive_low ? 1'b0 : 1'bz;   // open drain, pull-up is off chip

endmodule

// File: eeprom_slave_model.sv
`timescale 1ns/100ps

module eeprom_slave_model (
    inout wire  sda,
    input logic scl
);

    import eeprom_bus_pkg::*;

    typedef enum int {
        s_idle,
        s_ctrl,
        s_addr,
        s_wdata,
        s_rdata
    } slave_state_e;

    logic [7:0]   mem [0:2047];
    logic [3:0]   dev_code_expect = eeprom_dev_code;   // testbench may override
    slave_state_e st = s_idle;
    logic [3:0]   bit_cnt = 4'd0;
    logic [7:0]   shreg = 8'h00;
    logic [7:0]   word = 8'h00;
    logic [2:0]   blk = 3'd0;
    logic [7:0]   rd_byte = 8'h00;
    logic         rd_pending = 1'b0;
    logic         drive_low = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hff;   // erased
        end
    end

    // called on the falling scl after the eighth bit
    task automatic take_byte();
        ctrl_byte_u cb;
        cb.raw    = shreg;
        drive_low = 1'b1;
        case (st)
            s_ctrl: begin
                if (cb.fields.dev_code != dev_code_expect) begin
                    drive_low = 1'b0;   // not addressed
                    st        = s_idle;
                end else begin
                    blk = cb.fields.block;
                    if (cb.fields.rw == rw_read) begin
                        rd_byte    = mem[{blk, word}];
                        rd_pending = 1'b1;
                    end else begin
                        st = s_addr;
                    end
                end
            end
            s_addr: begin
                word = shreg;
                st   = s_wdata;
            end
            default: begin
                mem[{blk, word}] = shreg;
                st               = s_idle;   // no page writes
            end
        endcase
    endtask

    always @(negedge sda) begin
        if (scl === 1'b1) begin   // start or repeated start
            st         = s_ctrl;
            bit_cnt    = 4'd0;
            rd_pending = 1'b0;
            drive_low  = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            st = s_idle;   // stop
        end
    end

    always @(posedge scl) begin
        if (st != s_idle) begin
            if (bit_cnt < 4'd8) begin
                shreg   = {shreg[6:0], sda !== 1'b0};
                bit_cnt = bit_cnt + 4'd1;
            end else if (bit_cnt == 4'd8) begin
                if (st == s_rdata) begin
                    st = s_idle;   // single byte reads only
                end
                bit_cnt = 4'd9;
            end
        end
    end

    always @(negedge scl) begin
        if (st == s_idle) begin
            drive_low = 1'b0;
        end else if (bit_cnt == 4'd8) begin
            if (st == s_rdata) begin
                drive_low = 1'b0;   // master's ack slot
            end else begin
                take_byte();
            end
        end else if (bit_cnt == 4'd9) begin
            bit_cnt   = 4'd0;
            drive_low = 1'b0;
            if (rd_pending) begin
                rd_pending = 1'b0;
                st         = s_rdata;
                drive_low  = !rd_byte[7];
            end
        end else if (st == s_rdata && bit_cnt != 4'd0) begin
            drive_low = !rd_byte[7 - bit_cnt];
        end
    end

endmodule

// File: eeprom_i2c_checker.sv
`timescale 1ns/100ps

module eeprom_i2c_checker (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  eeprom_ctrl_pkg::eeprom_addr_t addr,
    input  logic [7:0]                    wdata,
    input  logic                          expect_nack,
    input  logic                          busy,
    input  logic                          ack,
    input  logic                          nack_err,
    input  logic [7:0]                    rdata,
    input  logic                          scl,
    input  wire                           sda,
    output int                            mismatch_cnt,
    output int                            fail_cnt
);

    import eeprom_ctrl_pkg::*;

    logic [7:0]  img [0:2047];
    eeprom_req_t pend;
    logic        pend_vld;
    logic        started;   // first strobe accepted

    initial begin
        for (int i = 0; i < 2048; i++) begin
            img[i] = 8'hff;
        end
        mismatch_cnt = 0;
        fail_cnt     = 0;
        pend_vld     = 1'b0;
        started      = 1'b0;
    end

    task automatic close_transfer();
        if (nack_err !== expect_nack) begin
            $display("MISMATCH %0t: nack_err %b, expected %b, addr %h",
                     $time, nack_err, expect_nack, pend.addr);
            mismatch_cnt++;
        end else if (!nack_err) begin
            if (!pend.is_read) begin
                img[pend.addr] = pend.wdata;
            end else if (rdata !== img[pend.addr]) begin
                $display("MISMATCH %0t: rdata %h, expected %h, addr %h",
                         $time, rdata, img[pend.addr], pend.addr);
                mismatch_cnt++;
            end
        end
    endtask

    always @(posedge CLK) begin
        if (!RESET) begin
            if (!started && (scl !== 1'b1 || sda !== 1'b1 || busy !== 1'b0 || ack !== 1'b0)) begin
                $display("%0t: bus or host outputs not idle after reset", $time);
                fail_cnt++;
            end
            // busy covers the whole transfer and is already low with ack
            if (ack && busy !== 1'b0) begin
                $display("%0t: busy still high in the ack cycle", $time);
                fail_cnt++;
            end else if (pend_vld && !ack && busy !== 1'b1) begin
                $display("%0t: busy low while a transfer is outstanding", $time);
                fail_cnt++;
            end
            if (ack) begin
                if (!pend_vld) begin
                    $display("%0t: ack with no transaction outstanding", $time);
                    fail_cnt++;
                end else begin
                    close_transfer();
                end
                pend_vld = 1'b0;
            end
            // the dut only takes a strobe while idle
            if (!busy && (wr || rd)) begin
                pend     = '{addr: addr, wdata: wdata, is_read: rd};
                pend_vld = 1'b1;
                started  = 1'b1;
            end
        end
    end

endmodule

// File: tb_eeprom_i2c.sv
`timescale 1ns/100ps

module tb_eeprom_i2c;

    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;

    localparam int scl_half_div = 4;
    localparam int clk_period   = 8;
    localparam int num_fixed    = 13;
    localparam int num_entries  = num_fixed + 8;
    // random read is 39 scl periods rounded up per entry
    localparam int frame_clks   = 48 * 2 * scl_half_div;
    localparam int limit_clks   = num_entries * (frame_clks + 16) + 100;

    typedef struct packed {
        logic         is_rd;
        eeprom_addr_t addr;
        logic [7:0]   wdata;
        logic         expect_nack;
        logic         bump;   // second strobe while busy
    } stim_t;

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    logic [7:0]   wdata;
    logic         busy;
    logic         ack;
    logic         nack_err;
    logic [7:0]   rdata;
    wire          sda;
    logic         scl;
    logic         expect_nack;
    int           mismatch_cnt;
    int           fail_cnt;
    stim_t        stim_tbl [num_entries];

    pullup (sda);

    eeprom_i2c_top #(
        .scl_half_div (scl_half_div)
    ) eeprom_i2c_top_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .ack      (ack),
        .nack_err (nack_err),
        .rdata    (rdata),
        .sda      (sda),
        .scl      (scl)
    );

    eeprom_slave_model slave_i (
        .sda (sda),
        .scl (scl)
    );

    eeprom_i2c_checker checker_i (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wdata        (wdata),
        .expect_nack  (expect_nack),
        .busy         (busy),
        .ack          (ack),
        .nack_err     (nack_err),
        .rdata        (rdata),
        .scl          (scl),
        .sda          (sda),
        .mismatch_cnt (mismatch_cnt),
        .fail_cnt     (fail_cnt)
    );

    initial begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    task automatic set_entry(int idx, logic r, eeprom_addr_t a, logic [7:0] d,
                             logic nack, logic bump);
        stim_tbl[idx] = '{is_rd: r, addr: a, wdata: d, expect_nack: nack, bump: bump};
    endtask

    task automatic fill_table();
        eeprom_addr_t a;
        logic [7:0]   d;
        set_entry(0,  1'b0, 11'h055, 8'ha5, 1'b0, 1'b0);
        set_entry(1,  1'b1, 11'h055, 8'h00, 1'b0, 1'b0);
        set_entry(2,  1'b1, 11'h3c0, 8'h00, 1'b0, 1'b0);   // never written
        set_entry(3,  1'b0, 11'h155, 8'h5a, 1'b0, 1'b0);   // same word in other blocks
        set_entry(4,  1'b0, 11'h755, 8'hc3, 1'b0, 1'b0);
        set_entry(5,  1'b1, 11'h055, 8'h00, 1'b0, 1'b0);
        set_entry(6,  1'b1, 11'h155, 8'h00, 1'b0, 1'b0);
        set_entry(7,  1'b1, 11'h755, 8'h00, 1'b0, 1'b0);
        set_entry(8,  1'b0, 11'h055, 8'h11, 1'b1, 1'b0);   // device stays silent
        set_entry(9,  1'b1, 11'h055, 8'h00, 1'b0, 1'b0);
        set_entry(10, 1'b1, 11'h2aa, 8'h00, 1'b1, 1'b0);
        set_entry(11, 1'b0, 11'h2aa, 8'h77, 1'b0, 1'b1);
        set_entry(12, 1'b1, 11'h2aa, 8'h00, 1'b0, 1'b1);
        for (int i = num_fixed; i < num_entries; i += 2) begin
            a = 11'($urandom_range(2047, 0));
            d = 8'($urandom);
            set_entry(i, 1'b0, a, d, 1'b0, 1'b0);
            set_entry(i + 1, 1'b1, a, 8'h00, 1'b0, 1'b0);
        end
    endtask

    task automatic run_entry(stim_t s);
        @(posedge CLK);
        wr          <= !s.is_rd;
        rd          <= s.is_rd;
        addr        <= s.addr;
        wdata       <= s.wdata;
        expect_nack <= s.expect_nack;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (s.bump) begin
            repeat (20) @(posedge CLK);
            wr    <= !s.is_rd;
            rd    <= s.is_rd;
            wdata <= ~s.wdata;
            @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
        end
        do
            @(negedge CLK);
        while (ack !== 1'b1);
    endtask

    initial begin
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = 8'h00;
        expect_nack = 1'b0;
        void'($urandom(93668));
        fill_table();
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        repeat (10) @(posedge CLK);   // idle bus after reset
        for (int i = 0; i < num_entries; i++) begin
            if (stim_tbl[i].expect_nack) begin
                slave_i.dev_code_expect = 4'b0110;
            end
            run_entry(stim_tbl[i]);
            slave_i.dev_code_expect = eeprom_dev_code;
        end
        repeat (10) @(posedge CLK);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(limit_clks * clk_period);
        $display("timeout: transactions did not finish within %0d clocks", limit_clks);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: flist.f
eeprom_bus_pkg.sv
eeprom_ctrl_pkg.sv
i2c_scl_gen.sv
i2c_bit_tx.sv
i2c_byte_rx.sv
eeprom_rw_ctrl.sv
eeprom_i2c_top.sv
eeprom_slave_model.sv
eeprom_i2c_checker.sv
tb_eeprom_i2c.sv

// File: Bender.yml
package:
  name: eeprom_i2c

sources:
  - eeprom_bus_pkg.sv
  - eeprom_ctrl_pkg.sv
  - i2c_scl_gen.sv
  - i2c_bit_tx.sv
  - i2c_byte_rx.sv
  - eeprom_rw_ctrl.sv
  - eeprom_i2c_top.sv
  - target: test
    files:
      - eeprom_slave_model.sv
      - eeprom_i2c_checker.sv
      - tb_eeprom_i2c.sv
